// ==== compile.f ====
+incdir+verif
common/isa_pkg.sv
common/ctrl_pkg.sv
control_unit/op_decoder.sv
control_unit/control_sequencer.sv
control_unit/control_combiner.sv
hdl/control_unit_top.sv
verif/control_unit_tb.sv

// ==== verif/control_unit_vectors.svh ====
`ifndef CONTROL_UNIT_VECTORS_SVH
`define CONTROL_UNIT_VECTORS_SVH

// Row columns are name, instr {opcode, ra, rb}, flags {z,n,c,v}, flag care mask,
// interrupt and expected ctrl
// One row per clock cycle, applied in order
task automatic load_vectors();
    ctrl_word_t w;
    add_row("nop",   {NOP, 2'd0, 2'd0},    4'h0, 4'h0, 1'b0, fetch_word());
    add_row("mov",   {MOV, 2'd1, 2'd2},    4'h0, 4'h0, 1'b0, reg_word(WB_ALU, 2'd1, ALU_PASS_B));
    add_row("add",   {ADD, 2'd2, 2'd3},    4'h0, 4'h0, 1'b0, reg_word(WB_ALU, 2'd2, ALU_ADD));
    add_row("sub",   {SUB, 2'd3, 2'd0},    4'h0, 4'h0, 1'b0, reg_word(WB_ALU, 2'd3, ALU_SUB));
    add_row("and",   {AND_OP, 2'd0, 2'd1}, 4'h0, 4'h0, 1'b0, reg_word(WB_ALU, 2'd0, ALU_AND));
    add_row("or",    {OR_OP, 2'd1, 2'd3},  4'h0, 4'h0, 1'b0, reg_word(WB_ALU, 2'd1, ALU_OR));
    add_row("rlc",   {ROT_CARRY, SUB_RLC, 2'd2}, 4'h0, 4'h0, 1'b0, reg_word(WB_ALU, 2'd2, ALU_RLC));
    add_row("rrc",   {ROT_CARRY, SUB_RRC, 2'd3}, 4'h0, 4'h0, 1'b0, reg_word(WB_ALU, 2'd3, ALU_RRC));
    w = fetch_word();
    w.setc = 1'b1;
    add_row("setc",  {ROT_CARRY, SUB_SETC, 2'd1}, 4'h0, 4'h0, 1'b0, w);
    w = fetch_word();
    w.clrc = 1'b1;
    add_row("clrc",  {ROT_CARRY, SUB_CLRC, 2'd2}, 4'h0, 4'h0, 1'b0, w);
    add_row("push",  {STACK_IO, SUB_PUSH, 2'd1}, 4'h0, 4'h0, 1'b0, push_word(PUSH_RB));
    w = reg_word(WB_MEM, 2'd2, ALU_NONE);   // Popped value into rb
    w.stack_pop = 1'b1;
    w.mem_src   = MA_SP;
    add_row("pop",   {STACK_IO, SUB_POP, 2'd2}, 4'h0, 4'h0, 1'b0, w);
    w = fetch_word();
    w.port_out_write = 1'b1;
    add_row("out",   {STACK_IO, SUB_OUT, 2'd3}, 4'h0, 4'h0, 1'b0, w);
    w = reg_word(WB_PORT, 2'd0, ALU_NONE);
    w.port_in_read = 1'b1;
    add_row("in",    {STACK_IO, SUB_IN, 2'd0}, 4'h0, 4'h0, 1'b0, w);
    add_row("unary", {UNARY, 2'd2, 2'd1},   4'h0, 4'h0, 1'b0, reg_word(WB_ALU, 2'd1, ALU_UNARY));
    // Branches with the selected flag cleared then set
    add_row("jz_0",  {COND_BRANCH, BR_Z, 2'd2}, 4'b0000, 4'b1000, 1'b0, fetch_word());
    add_row("jz_1",  {COND_BRANCH, BR_Z, 2'd2}, 4'b1000, 4'b1000, 1'b0, taken_word());
    add_row("jn_0",  {COND_BRANCH, BR_N, 2'd1}, 4'b0000, 4'b0100, 1'b0, fetch_word());
    add_row("jn_1",  {COND_BRANCH, BR_N, 2'd1}, 4'b0100, 4'b0100, 1'b0, taken_word());
    add_row("jc_0",  {COND_BRANCH, BR_C, 2'd3}, 4'b0000, 4'b0010, 1'b0, fetch_word());
    add_row("jc_1",  {COND_BRANCH, BR_C, 2'd3}, 4'b0010, 4'b0010, 1'b0, taken_word());
    add_row("jv_0",  {COND_BRANCH, BR_V, 2'd0}, 4'b0000, 4'b0001, 1'b0, fetch_word());
    add_row("jv_1",  {COND_BRANCH, BR_V, 2'd0}, 4'b0001, 4'b0001, 1'b0, taken_word());
    // Two-byte loads and stores with the immediate byte in the second row
    add_row("ldm",   {LOAD_STORE, SUB_LDM, 2'd1}, 4'h0, 4'h0, 1'b0,
            imm_word(reg_word(WB_IMM, 2'd1, ALU_NONE)));
    add_row("ldm_2", 8'h5a, 4'h0, 4'h0, 1'b0, fetch_word());
    w = reg_word(WB_MEM, 2'd2, ALU_NONE);
    w.mem_src = MA_IMM;
    add_row("ldd",   {LOAD_STORE, SUB_LDD, 2'd2}, 4'h0, 4'h0, 1'b0, imm_word(w));
    add_row("ldd_2", 8'hc1, 4'h0, 4'h0, 1'b0, fetch_word());     // Decodes as LDM but is data
    w = fetch_word();
    w.mem_write = 1'b1;
    w.mem_src   = MA_IMM;
    add_row("std",   {LOAD_STORE, SUB_STD, 2'd3}, 4'h0, 4'h0, 1'b0, imm_word(w));
    add_row("std_2", 8'h71, 4'h0, 4'h0, 1'b0, fetch_word());     // PUSH pattern as data
    add_row("ls_3",  {LOAD_STORE, 2'd3, 2'd1}, 4'h0, 4'h0, 1'b0, fetch_word());
    add_row("op_15", 8'hf6, 4'h0, 4'h0, 1'b0, fetch_word());
    // LOOP with its decision on Z in the next cycle
    w = reg_word(WB_ALU, 2'd1, ALU_UNARY);
    w.dec_ra = 1'b1;
    add_row("loop",      {LOOP, 2'd1, 2'd2}, 4'h0, 4'h0, 1'b0, w);
    add_row("loop_back", 8'h00, 4'b0000, 4'b1000, 1'b0, taken_word());
    add_row("loop",      {LOOP, 2'd1, 2'd2}, 4'h0, 4'h0, 1'b0, w);
    add_row("loop_exit", 8'h2d, 4'b1000, 4'b1000, 1'b0, fetch_word());
    // Jumps and register-indirect memory
    add_row("jmp",   {JUMP, SUB_JMP, 2'd1}, 4'h0, 4'h0, 1'b0, taken_word());
    w = push_word(PUSH_PC1);
    w.pc_src = PC_REG;                       // No flush on CALL
    add_row("call",  {JUMP, SUB_CALL, 2'd2}, 4'h0, 4'h0, 1'b0, w);
    w = fetch_word();
    w.stack_pop = 1'b1;
    w.pop_to_pc = 1'b1;
    w.pc_src    = PC_STACK;
    w.flush     = 1'b1;
    add_row("ret",   {JUMP, SUB_RET, 2'd0}, 4'h0, 4'h0, 1'b0, w);
    w.restore_flags = 1'b1;
    add_row("rti",   {JUMP, SUB_RTI, 2'd0}, 4'h0, 4'h0, 1'b0, w);
    w = reg_word(WB_MEM, 2'd3, ALU_NONE);
    w.mem_src = MA_REG;
    add_row("ldi",   {LDI, 2'd1, 2'd3}, 4'h0, 4'h0, 1'b0, w);
    w = fetch_word();
    w.mem_write = 1'b1;
    w.mem_src   = MA_REG;
    add_row("sti",   {STI, 2'd2, 2'd0}, 4'h0, 4'h0, 1'b0, w);
    // Interrupt raised in ST_FETCH and then in ST_FETCH2
    add_row("irq_fetch",  {ADD, 2'd0, 2'd1}, 4'h0, 4'h0, 1'b1, reg_word(WB_ALU, 2'd0, ALU_ADD));
    add_row("int_entry",  {MOV, 2'd1, 2'd1}, 4'h0, 4'h0, 1'b0, int_word());
    add_row("after_int",  {MOV, 2'd2, 2'd3}, 4'h0, 4'h0, 1'b0, reg_word(WB_ALU, 2'd2, ALU_PASS_B));
    add_row("ldm_irq",    {LOAD_STORE, SUB_LDM, 2'd2}, 4'h0, 4'h0, 1'b0,
            imm_word(reg_word(WB_IMM, 2'd2, ALU_NONE)));
    add_row("irq_fetch2", 8'h77, 4'h0, 4'h0, 1'b1, fetch_word());
    add_row("int_entry2", 8'h21, 4'h0, 4'h0, 1'b0, int_word());
    add_row("after_int2", {OR_OP, 2'd3, 2'd2}, 4'h0, 4'h0, 1'b0, reg_word(WB_ALU, 2'd3, ALU_OR));
endtask

`endif

// ==== verif/control_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit_tb;
    import isa_pkg::*;
    import ctrl_pkg::*;

    // One table row without its name
    typedef struct packed {
        instr_t     instr;
        logic [3:0] flags;          // {z, n, c, v}
        logic [3:0] care;           // Flags the row depends on
        logic       irq;
        ctrl_word_t exp;
    } vec_t;

    logic        clk;
    logic        rst;
    instr_t      instr;
    logic        z_flag;
    logic        n_flag;
    logic        c_flag;
    logic        v_flag;
    logic        interrupt;
    ctrl_word_t  ctrl;

    vec_t        rows[$];
    string       row_names[$];
    integer      seed;
    int unsigned cycle_count;
    int unsigned cycle_limit;
    int unsigned pass_count;
    int unsigned fail_count;

    control_unit_top uut (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .z_flag    (z_flag),
        .n_flag    (n_flag),
        .c_flag    (c_flag),
        .v_flag    (v_flag),
        .interrupt (interrupt),
        .ctrl      (ctrl)
    );

    always #20 clk = ~clk;          // 40 ns period

    // Plain fetch of the next opcode at PC+1
    function automatic ctrl_word_t fetch_word();
        ctrl_word_t w;
        w          = '0;
        w.mem_read = 1'b1;
        w.ir_write = 1'b1;
        w.pc_write = 1'b1;
        w.pc_src   = PC_INC;
        return w;
    endfunction

    function automatic ctrl_word_t reg_word(input wb_sel_e wb, input logic [1:0] dst,
                                            input alu_op_e op);
        ctrl_word_t w;
        w           = fetch_word();
        w.reg_write = 1'b1;
        w.reg_dst   = dst;
        w.wb_sel    = wb;
        w.alu_op    = op;
        return w;
    endfunction

    // Fetch redirected to R[rb]
    function automatic ctrl_word_t taken_word();
        ctrl_word_t w;
        w        = fetch_word();
        w.pc_src = PC_REG;
        w.flush  = 1'b1;
        return w;
    endfunction

    // First byte of LDM/LDD/STD, next byte goes to the immediate register
    function automatic ctrl_word_t imm_word(input ctrl_word_t w);
        w.ir_write  = 1'b0;
        w.imm_write = 1'b1;
        return w;
    endfunction

    function automatic ctrl_word_t push_word(input push_sel_e sel);
        ctrl_word_t w;
        w            = fetch_word();
        w.stack_push = 1'b1;
        w.mem_write  = 1'b1;
        w.mem_src    = MA_SP;
        w.push_sel   = sel;
        return w;
    endfunction

    // Interrupt entry pushes PC+1, saves flags and jumps through M[1]
    function automatic ctrl_word_t int_word();
        ctrl_word_t w;
        w            = push_word(PUSH_PC1);
        w.ir_write   = 1'b0;
        w.save_flags = 1'b1;
        w.pc_src     = PC_VEC1;
        w.flush      = 1'b1;
        return w;
    endfunction

    task automatic add_row(input string name, input logic [7:0] ins, input logic [3:0] flags,
                           input logic [3:0] care, input logic irq, input ctrl_word_t exp);
        vec_t v;
        v.instr = ins;
        v.flags = flags;
        v.care  = care;
        v.irq   = irq;
        v.exp   = exp;
        rows.push_back(v);
        row_names.push_back(name);
    endtask

    `include "control_unit_vectors.svh"

    // Run guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the table did not finish", cycle_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        vec_t        v;
        logic [31:0] rnd;
        int          i;
        clk         = 1'b0;
        rst         = 1'b1;
        instr       = '0;
        z_flag      = 1'b0;
        n_flag      = 1'b0;
        c_flag      = 1'b0;
        v_flag      = 1'b0;
        interrupt   = 1'b0;
        seed        = 28902;
        cycle_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        load_vectors();
        cycle_limit = 16 + rows.size() + 20;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (i = 0; i < rows.size(); i++) begin
            v   = rows[i];
            rnd = $random(seed);                // Fills flags the row ignores
            @(posedge clk);
            instr     <= v.instr;
            {z_flag, n_flag, c_flag, v_flag} <= (v.flags & v.care) | (rnd[3:0] & ~v.care);
            interrupt <= v.irq;
            @(negedge clk);                     // ctrl settled and state stable
            if (ctrl !== v.exp) begin
                $display("FAILED %s expected %h actual %h", row_names[i], v.exp, ctrl);
                fail_count++;
            end else begin
                $display("ok %s", row_names[i]);
                pass_count++;
            end
        end
        $display("Rows passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/control_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit_top (
    input  logic                 clk,
    input  logic                 rst,
    input  isa_pkg::instr_t      instr,
    input  logic                 z_flag,
    input  logic                 n_flag,
    input  logic                 c_flag,
    input  logic                 v_flag,
    input  logic                 interrupt,
    output ctrl_pkg::ctrl_word_t ctrl
);
    import ctrl_pkg::*;

    ctrl_word_t  dec_word;      // Normal-fetch word
    decode_req_t req;           // Two-byte, loop and branch requests
    seq_state_e  state;

    op_decoder u_op_decoder (
        .instr    (instr),
        .dec_word (dec_word),
        .req      (req)
    );

    control_sequencer u_control_sequencer (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .interrupt (interrupt),
        .state     (state)
    );

    control_combiner u_control_combiner (
        .state    (state),
        .dec_word (dec_word),
        .req      (req),
        .z_flag   (z_flag),
        .n_flag   (n_flag),
        .c_flag   (c_flag),
        .v_flag   (v_flag),
        .ctrl     (ctrl)
    );

endmodule

`default_nettype wire

// ==== control_unit/control_combiner.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_combiner (
    input  ctrl_pkg::seq_state_e  state,
    input  ctrl_pkg::ctrl_word_t  dec_word,
    input  ctrl_pkg::decode_req_t req,
    input  logic                  z_flag,
    input  logic                  n_flag,
    input  logic                  c_flag,
    input  logic                  v_flag,
    output ctrl_pkg::ctrl_word_t  ctrl
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic sel_flag;                         // Flag picked by br_sel

    always_comb begin
        case (req.br_sel)
            BR_Z:    sel_flag = z_flag;
            BR_N:    sel_flag = n_flag;
            BR_C:    sel_flag = c_flag;
            default: sel_flag = v_flag;     // BR_V
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (state)
            ST_FETCH: begin
                ctrl = dec_word;
                if (req.cond_branch && sel_flag) begin
                    ctrl.pc_src = PC_REG;   // Taken branch to R[rb]
                    ctrl.flush  = 1'b1;
                end
            end
            ST_FETCH2: begin                // Immediate byte already latched
                ctrl.mem_read = 1'b1;
                ctrl.ir_write = 1'b1;
                ctrl.pc_write = 1'b1;
                ctrl.pc_src   = PC_INC;     // Two increments give PC+2
            end
            ST_LOOP: begin
                ctrl.mem_read = 1'b1;
                ctrl.ir_write = 1'b1;
                ctrl.pc_write = 1'b1;
                if (!z_flag) begin          // Count not yet zero
                    ctrl.pc_src = PC_REG;
                    ctrl.flush  = 1'b1;
                end else begin
                    ctrl.pc_src = PC_INC;
                end
            end
            default: begin                  // ST_INT
                ctrl.save_flags = 1'b1;
                ctrl.stack_push = 1'b1;
                ctrl.push_sel   = PUSH_PC1;
                ctrl.mem_write  = 1'b1;
                ctrl.mem_read   = 1'b1;     // Vector read from M[1]
                ctrl.mem_src    = MA_SP;
                ctrl.pc_write   = 1'b1;
                ctrl.pc_src     = PC_VEC1;
                ctrl.flush      = 1'b1;     // Fetched byte runs again after RTI
            end
        endcase
    end

    // A flushed fetch always loads a new PC
    a_flush_moves_pc: assert property (@(ctrl) ctrl.flush |-> ctrl.pc_write);

    // Carry set and clear never pulse together
    a_carry_exclusive: assert property (@(ctrl) !(ctrl.setc && ctrl.clrc));

endmodule

`default_nettype wire

// ==== control_unit/control_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  ctrl_pkg::decode_req_t req,
    input  logic                  interrupt,
    output ctrl_pkg::seq_state_e  state
);
    import ctrl_pkg::*;

    seq_state_e next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = ST_FETCH;              // Every extra state lasts one cycle
        case (state)
            ST_FETCH: begin
                if (interrupt) begin
                    next_state = ST_INT;    // Interrupt wins over a pending second byte
                end else if (req.two_byte) begin
                    next_state = ST_FETCH2;
                end else if (req.loop) begin
                    next_state = ST_LOOP;
                end
            end
            ST_FETCH2, ST_LOOP: begin
                if (interrupt) begin
                    next_state = ST_INT;    // Taken once the instruction completes
                end
            end
            default: begin                  // ST_INT back to normal fetch
                next_state = ST_FETCH;
            end
        endcase
    end

    // Interrupt entry is a single cycle
    a_int_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        state == ST_INT |=> state == ST_FETCH
    );

    // Decoder never asks for both extra states at once
    a_req_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(req.two_byte && req.loop)
    );

endmodule

`default_nettype wire

// ==== control_unit/op_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module op_decoder (
    input  isa_pkg::instr_t      instr,
    output ctrl_pkg::ctrl_word_t dec_word,
    output ctrl_pkg::decode_req_t req
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    always_comb begin
        dec_word          = '0;
        req               = '0;
        dec_word.ir_write = 1'b1;       // Next byte is an opcode by default
        dec_word.mem_read = 1'b1;       // Fetch read
        dec_word.pc_write = 1'b1;
        dec_word.pc_src   = PC_INC;

        case (instr.opcode)
            NOP: begin
            end
            MOV: begin
                dec_word.alu_op    = ALU_PASS_B;
                dec_word.reg_write = 1'b1;
                dec_word.reg_dst   = instr.ra;
                dec_word.wb_sel    = WB_ALU;
            end
            ADD: begin
                dec_word.alu_op    = ALU_ADD;
                dec_word.reg_write = 1'b1;
                dec_word.reg_dst   = instr.ra;
                dec_word.wb_sel    = WB_ALU;
            end
            SUB: begin
                dec_word.alu_op    = ALU_SUB;
                dec_word.reg_write = 1'b1;
                dec_word.reg_dst   = instr.ra;
                dec_word.wb_sel    = WB_ALU;
            end
            AND_OP: begin
                dec_word.alu_op    = ALU_AND;
                dec_word.reg_write = 1'b1;
                dec_word.reg_dst   = instr.ra;
                dec_word.wb_sel    = WB_ALU;
            end
            OR_OP: begin
                dec_word.alu_op    = ALU_OR;
                dec_word.reg_write = 1'b1;
                dec_word.reg_dst   = instr.ra;
                dec_word.wb_sel    = WB_ALU;
            end
            ROT_CARRY: begin
                case (instr.ra)
                    SUB_RLC, SUB_RRC: begin
                        dec_word.alu_op    = (instr.ra == SUB_RLC) ? ALU_RLC : ALU_RRC;
                        dec_word.reg_write = 1'b1;
                        dec_word.reg_dst   = instr.rb;      // Rotates work in place on rb
                        dec_word.wb_sel    = WB_ALU;
                    end
                    SUB_SETC: dec_word.setc = 1'b1;
                    default:  dec_word.clrc = 1'b1;         // SUB_CLRC
                endcase
            end
            STACK_IO: begin
                case (instr.ra)
                    SUB_PUSH: begin                         // M[SP--] <- R[rb]
                        dec_word.stack_push = 1'b1;
                        dec_word.mem_write  = 1'b1;
                        dec_word.mem_src    = MA_SP;
                        dec_word.push_sel   = PUSH_RB;
                    end
                    SUB_POP: begin                          // R[rb] <- M[++SP]
                        dec_word.stack_pop = 1'b1;
                        dec_word.mem_src   = MA_SP;
                        dec_word.reg_write = 1'b1;
                        dec_word.reg_dst   = instr.rb;
                        dec_word.wb_sel    = WB_MEM;
                    end
                    SUB_OUT: dec_word.port_out_write = 1'b1; // Port takes R[rb]
                    default: begin                          // SUB_IN
                        dec_word.port_in_read = 1'b1;
                        dec_word.reg_write    = 1'b1;
                        dec_word.reg_dst      = instr.rb;
                        dec_word.wb_sel       = WB_PORT;
                    end
                endcase
            end
            UNARY: begin
                dec_word.alu_op    = ALU_UNARY;
                dec_word.reg_write = 1'b1;
                dec_word.reg_dst   = instr.rb;
                dec_word.wb_sel    = WB_ALU;
            end
            COND_BRANCH: begin
                req.cond_branch = 1'b1;     // Taken/not taken resolved in combiner
                req.br_sel      = instr.ra;
            end
            LOOP: begin
                dec_word.alu_op    = ALU_UNARY;
                dec_word.dec_ra    = 1'b1;  // Decrement count in ra
                dec_word.reg_write = 1'b1;
                dec_word.reg_dst   = instr.ra;
                dec_word.wb_sel    = WB_ALU;
                req.loop           = 1'b1;  // Branch decided next cycle on Z
            end
            JUMP: begin
                case (instr.ra)
                    SUB_JMP: begin
                        dec_word.pc_src = PC_REG;
                        dec_word.flush  = 1'b1;
                    end
                    SUB_CALL: begin                         // Push PC+1, jump to R[rb]
                        dec_word.pc_src     = PC_REG;
                        dec_word.stack_push = 1'b1;
                        dec_word.mem_write  = 1'b1;
                        dec_word.mem_src    = MA_SP;
                        dec_word.push_sel   = PUSH_PC1;
                    end
                    default: begin                          // RET and RTI
                        dec_word.stack_pop     = 1'b1;
                        dec_word.pop_to_pc     = 1'b1;
                        dec_word.pc_src        = PC_STACK;
                        dec_word.flush         = 1'b1;
                        dec_word.restore_flags = (instr.ra == SUB_RTI);
                    end
                endcase
            end
            LOAD_STORE: begin
                if (instr.ra != 2'd3) begin                 // Code 3 is a NOP
                    req.two_byte       = 1'b1;
                    dec_word.ir_write  = 1'b0;              // Next byte is the immediate
                    dec_word.imm_write = 1'b1;
                end
                case (instr.ra)
                    SUB_LDM: begin
                        dec_word.reg_write = 1'b1;
                        dec_word.reg_dst   = instr.rb;
                        dec_word.wb_sel    = WB_IMM;
                    end
                    SUB_LDD: begin
                        dec_word.reg_write = 1'b1;
                        dec_word.reg_dst   = instr.rb;
                        dec_word.wb_sel    = WB_MEM;
                        dec_word.mem_src   = MA_IMM;
                    end
                    SUB_STD: begin
                        dec_word.mem_write = 1'b1;
                        dec_word.mem_src   = MA_IMM;
                    end
                    default: begin
                    end
                endcase
            end
            LDI: begin                                      // R[rb] <- M[R[ra]]
                dec_word.reg_write = 1'b1;
                dec_word.reg_dst   = instr.rb;
                dec_word.wb_sel    = WB_MEM;
                dec_word.mem_src   = MA_REG;
            end
            STI: begin                                      // M[R[ra]] <- R[rb]
                dec_word.mem_write = 1'b1;
                dec_word.mem_src   = MA_REG;
            end
            default: begin                                  // Opcode 15, plain fetch
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== common/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    // Sequencer states
    typedef enum logic [1:0] {
        ST_FETCH  = 2'd0,       // Normal decode
        ST_FETCH2 = 2'd1,       // Second byte of LDM/LDD/STD
        ST_INT    = 2'd2,       // Interrupt entry
        ST_LOOP   = 2'd3        // LOOP branch decision
    } seq_state_e;

    // Next PC select in the fetch unit
    typedef enum logic [2:0] {
        PC_INC   = 3'd0,        // PC+1
        PC_INC2  = 3'd1,        // PC+2
        PC_REG   = 3'd2,        // PC <- R[rb]
        PC_STACK = 3'd3,        // Popped return address
        PC_VEC0  = 3'd4,        // M[0], reset vector
        PC_VEC1  = 3'd5         // M[1], interrupt vector
    } pc_src_e;

    // Register file write-back select
    typedef enum logic [2:0] {
        WB_MEM  = 3'd0,
        WB_PC   = 3'd1,
        WB_IMM  = 3'd2,
        WB_ALU  = 3'd3,
        WB_PORT = 3'd4          // Input port
    } wb_sel_e;

    // Memory address select
    typedef enum logic [1:0] {
        MA_PC  = 2'd0,
        MA_REG = 2'd1,          // R[ra]
        MA_SP  = 2'd2,
        MA_IMM = 2'd3           // Immediate register
    } mem_src_e;

    // Data pushed on the stack
    typedef enum logic [1:0] {
        PUSH_RB  = 2'd0,
        PUSH_PC1 = 2'd1,        // Return address
        PUSH_PC  = 2'd2
    } push_sel_e;

    // Full control word to the datapath
    typedef struct packed {
        isa_pkg::alu_op_e alu_op;
        logic             dec_ra;           // Unary ALU decrements ra (LOOP)
        logic             reg_write;
        logic [1:0]       reg_dst;          // Destination register index
        wb_sel_e          wb_sel;
        logic             mem_read;
        logic             mem_write;
        mem_src_e         mem_src;
        push_sel_e        push_sel;
        logic             pop_to_pc;        // Pop goes to PC, not rb
        logic             pc_write;
        pc_src_e          pc_src;
        logic             ir_write;
        logic             imm_write;
        logic             stack_push;
        logic             stack_pop;
        logic             setc;
        logic             clrc;
        logic             save_flags;
        logic             restore_flags;
        logic             port_out_write;
        logic             port_in_read;
        logic             flush;            // Kill the fetched byte
    } ctrl_word_t;

    // Decoder requests to sequencer and combiner
    typedef struct packed {
        logic       two_byte;               // Go to ST_FETCH2
        logic       loop;                   // Go to ST_LOOP
        logic       cond_branch;            // Combiner checks a flag
        logic [1:0] br_sel;                 // Which flag
    } decode_req_t;

endpackage

`default_nettype wire

// ==== common/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // Major opcode, upper nibble of the instruction byte
    typedef enum logic [3:0] {
        NOP         = 4'd0,
        MOV         = 4'd1,     // R[ra] <- R[rb]
        ADD         = 4'd2,
        SUB         = 4'd3,
        AND_OP      = 4'd4,
        OR_OP       = 4'd5,
        ROT_CARRY   = 4'd6,     // RLC, RRC, SETC, CLRC
        STACK_IO    = 4'd7,     // PUSH, POP, OUT, IN
        UNARY       = 4'd8,     // NOT, NEG, INC, DEC picked by the ALU
        COND_BRANCH = 4'd9,     // JZ, JN, JC, JV
        LOOP        = 4'd10,    // R[ra]--, branch to R[rb] if nonzero
        JUMP        = 4'd11,    // JMP, CALL, RET, RTI
        LOAD_STORE  = 4'd12,    // LDM, LDD, STD (two bytes)
        LDI         = 4'd13,    // R[rb] <- M[R[ra]]
        STI         = 4'd14     // M[R[ra]] <- R[rb]
    } opcode_e;

    // One instruction byte
    typedef struct packed {
        opcode_e    opcode;
        logic [1:0] ra;         // Also the sub-op or branch select
        logic [1:0] rb;
    } instr_t;

    // Operation code sent to the ALU
    typedef enum logic [3:0] {
        ALU_NONE   = 4'd0,
        ALU_PASS_B = 4'd1,      // MOV
        ALU_ADD    = 4'd2,
        ALU_SUB    = 4'd3,
        ALU_AND    = 4'd4,
        ALU_OR     = 4'd5,
        ALU_RLC    = 4'd6,
        ALU_RRC    = 4'd7,
        ALU_UNARY  = 4'd8       // Also LOOP decrement with dec_ra
    } alu_op_e;

    // ra-field codes under ROT_CARRY
    localparam logic [1:0] SUB_RLC  = 2'd0;
    localparam logic [1:0] SUB_RRC  = 2'd1;
    localparam logic [1:0] SUB_SETC = 2'd2;
    localparam logic [1:0] SUB_CLRC = 2'd3;

    // Under STACK_IO
    localparam logic [1:0] SUB_PUSH = 2'd0;
    localparam logic [1:0] SUB_POP  = 2'd1;
    localparam logic [1:0] SUB_OUT  = 2'd2;
    localparam logic [1:0] SUB_IN   = 2'd3;

    // Under JUMP
    localparam logic [1:0] SUB_JMP  = 2'd0;
    localparam logic [1:0] SUB_CALL = 2'd1;
    localparam logic [1:0] SUB_RET  = 2'd2;
    localparam logic [1:0] SUB_RTI  = 2'd3;

    // Under LOAD_STORE, code 3 unused
    localparam logic [1:0] SUB_LDM  = 2'd0;
    localparam logic [1:0] SUB_LDD  = 2'd1;
    localparam logic [1:0] SUB_STD  = 2'd2;

    // Flag select of COND_BRANCH
    localparam logic [1:0] BR_Z     = 2'd0;
    localparam logic [1:0] BR_N     = 2'd1;
    localparam logic [1:0] BR_C     = 2'd2;
    localparam logic [1:0] BR_V     = 2'd3;

endpackage

`default_nettype wire
